// ==== logic/decodePkg.sv ====
/* Decode stage package
   Instruction views, control word, forwarding and ID/EX bundle types */
package decodePkg;

	localparam int XLen     = 32;
	localparam int RegCount = 32;

	typedef logic [XLen-1:0] WordT;
	typedef logic [4:0]      RegIdxT;

	localparam RegIdxT LinkReg    = 5'd31;
	localparam RegIdxT SysArgReg  = 5'd2;  // Syscall code register
	localparam WordT   LinkOffset = 32'd4;

	// --------------------
	// Instruction word views
	typedef struct packed {
		logic [5:0] opcode;
		RegIdxT     rs;
		RegIdxT     rt;
		RegIdxT     rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} RTypeT;

	typedef struct packed {
		logic [5:0]  opcode;
		RegIdxT      rs;
		RegIdxT      rt;
		logic [15:0] imm16;
	} ITypeT;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [25:0] target26;
	} JTypeT;

	typedef union packed {
		RTypeT rType;
		ITypeT iType;
		JTypeT jType;
	} InstrU;

	// --------------------
	// Control encodings
	typedef enum logic [4:0] {
		AluAdd, AluAddu, AluSub, AluSubu, AluAnd, AluOr, AluXor, AluNor,
		AluSlt, AluSltu, AluSll, AluSrl, AluSra, AluSllv, AluSrlv, AluSrav, AluLui
	} AluOpT;

	typedef enum logic [2:0] {
		BrNone, BrEq, BrNe, BrLez, BrGtz, BrLtz, BrGez
	} BranchKindT;

	typedef struct packed {
		logic       link;
		logic       regDst;
		logic       jump;
		logic       jumpReg;   // Target from rs
		logic       memRead;
		logic       memToReg;
		logic       memWrite;
		logic       aluSrc;
		logic       regWrite;
		logic       signExt;
		logic       syscall;
		BranchKindT branchKind;
		AluOpT      aluOp;
	} CtrlT;

	// Write-back source seen by the forwarding logic
	typedef struct packed {
		logic   valid;
		RegIdxT dest;
		WordT   data;
	} FwdSrcT;

	typedef struct packed {
		WordT   opA;
		WordT   opB;
		WordT   storeData;
		RegIdxT dest;
		RegIdxT srcA;
		RegIdxT srcB;
		RegIdxT shamt;
		AluOpT  aluOp;
		logic   memRead;
		logic   memWrite;
		logic   memToReg;
		logic   aluSrc;
		logic   writeBack;
		logic   takenBranch;
	} IdExT;

endpackage

// ==== logic/controlDecoder.sv ====
/* Control decoder
   Maps opcode, funct and rt onto the control word */
`timescale 1ns/1ps

module controlDecoder (
	input  decodePkg::InstrU instr,
	output decodePkg::CtrlT  ctrl
);
	import decodePkg::*;

	AluOpT rAluOp;
	logic  rAluHit;  // funct is one of the R-type ALU ops

	// Immediate-operand ALU instruction
	function automatic CtrlT immCtrl(input AluOpT op, input logic ext);
		CtrlT c;
		c          = '0;
		c.aluSrc   = 1'b1;
		c.regWrite = 1'b1;
		c.signExt  = ext;
		c.aluOp    = op;
		return c;
	endfunction

	// --------------------
	// SPECIAL funct table
	always_comb begin
		rAluHit = 1'b1;
		rAluOp  = AluAddu;
		case (instr.rType.funct)
			6'b000000: rAluOp = AluSll;  // Also nop
			6'b000010: rAluOp = AluSrl;
			6'b000011: rAluOp = AluSra;
			6'b000100: rAluOp = AluSllv;
			6'b000110: rAluOp = AluSrlv;
			6'b000111: rAluOp = AluSrav;
			6'b100000: rAluOp = AluAdd;
			6'b100001: rAluOp = AluAddu;
			6'b100010: rAluOp = AluSub;
			6'b100011: rAluOp = AluSubu;
			6'b100100: rAluOp = AluAnd;
			6'b100101: rAluOp = AluOr;
			6'b100110: rAluOp = AluXor;
			6'b100111: rAluOp = AluNor;
			6'b101010: rAluOp = AluSlt;
			6'b101011: rAluOp = AluSltu;
			default:   rAluHit = 1'b0;
		endcase
	end

	// --------------------
	// Opcode table
	always_comb begin
		ctrl = '0;
		case (instr.rType.opcode)
			6'b000000: begin
				if (rAluHit) begin
					ctrl.regDst   = 1'b1;
					ctrl.regWrite = 1'b1;
					ctrl.aluOp    = rAluOp;
				end else if (instr.rType.funct == 6'b001000) begin  // jr
					ctrl.jump    = 1'b1;
					ctrl.jumpReg = 1'b1;
				end else if (instr.rType.funct == 6'b001001) begin  // jalr
					ctrl.link     = 1'b1;
					ctrl.regDst   = 1'b1;
					ctrl.jump     = 1'b1;
					ctrl.jumpReg  = 1'b1;
					ctrl.regWrite = 1'b1;
					ctrl.aluOp    = AluAddu;
				end else if (instr.rType.funct == 6'b001100) begin  // syscall
					ctrl.syscall = 1'b1;
					ctrl.aluOp   = AluAddu;
				end
			end
			6'b000001: begin  // REGIMM
				if (instr.rType.rt == 5'b00000)
					ctrl.branchKind = BrLtz;
				else if (instr.rType.rt == 5'b00001)
					ctrl.branchKind = BrGez;
			end
			6'b000010: ctrl.jump = 1'b1;  // j
			6'b000011: begin  // jal
				ctrl.link     = 1'b1;
				ctrl.jump     = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.aluOp    = AluAddu;
			end
			6'b000100: ctrl.branchKind = BrEq;
			6'b000101: ctrl.branchKind = BrNe;
			6'b000110: ctrl.branchKind = BrLez;
			6'b000111: ctrl.branchKind = BrGtz;
			6'b001000: ctrl = immCtrl(AluAdd, 1'b1);
			6'b001001: ctrl = immCtrl(AluAddu, 1'b1);
			6'b001010: ctrl = immCtrl(AluSlt, 1'b1);
			6'b001011: ctrl = immCtrl(AluSltu, 1'b1);
			6'b001100: ctrl = immCtrl(AluAnd, 1'b0);
			6'b001101: ctrl = immCtrl(AluOr, 1'b0);
			6'b001110: ctrl = immCtrl(AluXor, 1'b0);
			6'b001111: ctrl = immCtrl(AluLui, 1'b0);
			6'b100000, 6'b100001, 6'b100011, 6'b100100, 6'b100101: begin  // Loads
				ctrl          = immCtrl(AluAddu, 1'b1);
				ctrl.memRead  = 1'b1;
				ctrl.memToReg = 1'b1;
			end
			6'b101000, 6'b101001, 6'b101011: begin  // Stores
				ctrl          = immCtrl(AluAddu, 1'b1);
				ctrl.regWrite = 1'b0;
				ctrl.memWrite = 1'b1;
			end
			default: ctrl = '0;
		endcase
	end

endmodule

// ==== logic/registerFile.sv ====
/* Register file
   32 words, one write-back port, two reads plus the syscall argument */
`timescale 1ns/1ps

module registerFile (
	input  logic              CLK,
	input  logic              RESET,
	input  decodePkg::FwdSrcT wb,
	input  decodePkg::RegIdxT idxA,
	input  decodePkg::RegIdxT idxB,
	output decodePkg::WordT   dataA,
	output decodePkg::WordT   dataB,
	output decodePkg::WordT   sysArg
);
	import decodePkg::*;

	WordT regs [RegCount];

	always_ff @(posedge CLK) begin
		if (wb.valid)
			regs[wb.dest] <= wb.data;
	end

	// Register 0 reads as zero, it is never written
	assign dataA  = (idxA == '0) ? '0 : regs[idxA];
	assign dataB  = (idxB == '0) ? '0 : regs[idxB];
	assign sysArg = regs[SysArgReg];

	// Producers upstream must drop writes to register 0
	wbNotZero: assert property (@(posedge CLK) disable iff (!RESET)
		wb.valid |-> wb.dest != '0);

endmodule

// ==== logic/operandForward.sv ====
/* Operand forwarding for branch resolution
   Priority EX, MEM, WB, then the register file value */
`timescale 1ns/1ps

module operandForward (
	input  decodePkg::RegIdxT srcA,
	input  decodePkg::RegIdxT srcB,
	input  decodePkg::WordT   regA,
	input  decodePkg::WordT   regB,
	input  decodePkg::FwdSrcT exSrc,
	input  decodePkg::FwdSrcT memSrc,
	input  decodePkg::FwdSrcT wbSrc,
	output decodePkg::WordT   fwdA,
	output decodePkg::WordT   fwdB
);
	import decodePkg::*;

	// Youngest matching producer wins
	function automatic WordT pick(input RegIdxT idx, input WordT regVal);
		WordT v;
		v = regVal;
		if (idx != '0) begin  // r0 stays zero
			if (exSrc.valid && exSrc.dest == idx)
				v = exSrc.data;
			else if (memSrc.valid && memSrc.dest == idx)
				v = memSrc.data;
			else if (wbSrc.valid && wbSrc.dest == idx)
				v = wbSrc.data;
		end
		return v;
	endfunction

	always_comb begin
		fwdA = pick(srcA, regA);
		fwdB = pick(srcB, regB);
	end

endmodule

// ==== logic/branchResolve.sv ====
/* Branch and jump resolution
   Evaluates the condition and picks the next fetch address */
`timescale 1ns/1ps

module branchResolve (
	input  decodePkg::InstrU instr,
	input  decodePkg::CtrlT  ctrl,
	input  decodePkg::WordT  pca,
	input  decodePkg::WordT  fwdA,
	input  decodePkg::WordT  fwdB,
	output decodePkg::WordT  nextAddress,
	output logic             taken
);
	import decodePkg::*;

	logic condMet;
	WordT branchTarget;
	WordT jumpTarget;

	// --------------------
	// Condition
	always_comb begin
		case (ctrl.branchKind)
			BrEq:    condMet = (fwdA == fwdB);
			BrNe:    condMet = (fwdA != fwdB);
			BrLez:   condMet = ($signed(fwdA) <= 0);
			BrGtz:   condMet = ($signed(fwdA) > 0);
			BrLtz:   condMet = fwdA[XLen-1];
			BrGez:   condMet = !fwdA[XLen-1];
			default: condMet = 1'b0;
		endcase
	end

	// --------------------
	// Targets
	assign branchTarget = pca + {{14{instr.iType.imm16[15]}}, instr.iType.imm16, 2'b00};
	assign jumpTarget   = ctrl.jumpReg ? fwdA
	                                   : {pca[XLen-1:28], instr.jType.target26, 2'b00};

	assign taken       = ctrl.jump | condMet;  // Jumps redirect fetch too
	assign nextAddress = ctrl.jump ? jumpTarget
	                   : condMet   ? branchTarget
	                               : pca;

endmodule

// ==== logic/idExRegister.sv ====
/* ID/EX pipeline register
   Operand selection, freeze hold and the syscall bubble sequence */
`timescale 1ns/1ps

module idExRegister #(
	parameter int SyscallBubbles = 3
) (
	input  logic             CLK,
	input  logic             RESET,
	input  logic             freeze,
	input  decodePkg::InstrU instr,
	input  decodePkg::CtrlT  ctrl,
	input  decodePkg::WordT  pca,
	input  decodePkg::WordT  regA,
	input  decodePkg::WordT  regB,
	input  decodePkg::WordT  sysArg,
	input  logic             taken,
	output decodePkg::IdExT  idEx,
	output logic             insertBubble,
	output logic             sysOut
);
	import decodePkg::*;

	localparam int CntW = (SyscallBubbles > 0) ? $clog2(SyscallBubbles + 1) : 1;

	logic [CntW-1:0] bubbleCnt;
	WordT            extImm;
	IdExT            nextIdEx;

	assign extImm = ctrl.signExt ? {{16{instr.iType.imm16[15]}}, instr.iType.imm16}
	                             : {16'b0, instr.iType.imm16};

	// --------------------
	// Next contents
	always_comb begin
		nextIdEx = '0;
		nextIdEx.opA = ctrl.link ? pca : ctrl.syscall ? sysArg : regA;
		if (ctrl.link)
			nextIdEx.opB = LinkOffset;
		else if (ctrl.syscall)
			nextIdEx.opB = '0;
		else
			nextIdEx.opB = ctrl.aluSrc ? extImm : regB;
		if (ctrl.regDst)
			nextIdEx.dest = instr.rType.rd;
		else if (ctrl.link)
			nextIdEx.dest = LinkReg;
		else if (ctrl.syscall)
			nextIdEx.dest = '0;
		else
			nextIdEx.dest = instr.rType.rt;
		nextIdEx.srcA = (ctrl.link || ctrl.syscall) ? '0 : instr.rType.rs;
		nextIdEx.srcB = (ctrl.aluSrc || ctrl.link || ctrl.syscall) ? '0 : instr.rType.rt;
		nextIdEx.storeData   = regB;
		nextIdEx.shamt       = instr.rType.shamt;
		nextIdEx.aluOp       = ctrl.aluOp;
		nextIdEx.memRead     = ctrl.memRead;
		nextIdEx.memWrite    = ctrl.memWrite;
		nextIdEx.memToReg    = ctrl.memToReg;
		nextIdEx.aluSrc      = ctrl.aluSrc;
		nextIdEx.writeBack   = (ctrl.regWrite || ctrl.memToReg) && nextIdEx.dest != '0;
		nextIdEx.takenBranch = taken;
	end

	// --------------------
	// Syscall sequencing
	assign insertBubble = ctrl.syscall && bubbleCnt != '0;
	assign sysOut       = ctrl.syscall && bubbleCnt == '0;

	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			bubbleCnt <= CntW'(SyscallBubbles);
		end else if (!freeze) begin
			if (insertBubble)
				bubbleCnt <= bubbleCnt - 1'b1;
			else
				bubbleCnt <= CntW'(SyscallBubbles);  // Other instr or issue edge
		end
	end

	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET)
			idEx <= '0;
		else if (!freeze)
			idEx <= insertBubble ? '0 : nextIdEx;
	end

endmodule

// ==== logic/decodeStage.sv ====
/* Instruction decode stage
   Decode, register read, branch resolution and the ID/EX register */
`timescale 1ns/1ps

module decodeStage #(
	parameter int SyscallBubbles = 3
) (
	input  logic              CLK,
	input  logic              RESET,
	input  decodePkg::InstrU  instr,
	input  decodePkg::WordT   pca,
	input  decodePkg::WordT   exResult,
	input  decodePkg::FwdSrcT memFwd,
	input  decodePkg::FwdSrcT wbFwd,
	input  logic              freeze,
	output decodePkg::IdExT   idEx,
	output decodePkg::WordT   nextAddress,
	output logic              takenBranch,
	output logic              insertBubble,
	output logic              sysOut
);
	import decodePkg::*;

	CtrlT   ctrl;
	WordT   regA;
	WordT   regB;
	WordT   sysArg;
	WordT   fwdA;
	WordT   fwdB;
	FwdSrcT exSrc;

	// EX result pairs with the destination held in ID/EX
	assign exSrc = '{valid: idEx.writeBack, dest: idEx.dest, data: exResult};

	controlDecoder decoder (
		.instr (instr),
		.ctrl  (ctrl)
	);

	registerFile regFile (
		.CLK    (CLK),
		.RESET  (RESET),
		.wb     (wbFwd),
		.idxA   (instr.rType.rs),
		.idxB   (instr.rType.rt),
		.dataA  (regA),
		.dataB  (regB),
		.sysArg (sysArg)
	);

	operandForward forward (
		.srcA   (instr.rType.rs),
		.srcB   (instr.rType.rt),
		.regA   (regA),
		.regB   (regB),
		.exSrc  (exSrc),
		.memSrc (memFwd),
		.wbSrc  (wbFwd),
		.fwdA   (fwdA),
		.fwdB   (fwdB)
	);

	branchResolve resolve (
		.instr       (instr),
		.ctrl        (ctrl),
		.pca         (pca),
		.fwdA        (fwdA),
		.fwdB        (fwdB),
		.nextAddress (nextAddress),
		.taken       (takenBranch)
	);

	idExRegister #(
		.SyscallBubbles (SyscallBubbles)
	) pipeReg (
		.CLK          (CLK),
		.RESET        (RESET),
		.freeze       (freeze),
		.instr        (instr),
		.ctrl         (ctrl),
		.pca          (pca),
		.regA         (regA),
		.regB         (regB),
		.sysArg       (sysArg),
		.taken        (takenBranch),
		.idEx         (idEx),
		.insertBubble (insertBubble),
		.sysOut       (sysOut)
	);

endmodule

// ==== verif/tbClock.sv ====
/* Testbench clock and reset
   Free-running clock, active-low reset held for a number of cycles */
`timescale 1ns/1ps

module tbClock #(
	parameter int Period      = 100,
	parameter int ResetCycles = 10
) (
	output logic CLK,
	output logic RESET
);

	initial begin
		CLK = 1'b0;
		forever #(Period / 2) CLK = ~CLK;
	end

	initial begin
		RESET = 1'b0;
		repeat (ResetCycles) @(posedge CLK);
		RESET <= 1'b1;  // Release on a rising edge
	end

endmodule

// ==== verif/decodeStageTb.sv ====
/* Decode stage testbench
   Directed tests of decode, forwarding, branches, jumps and syscall bubbles */
`timescale 1ns/1ps

module decodeStageTb;
	import decodePkg::*;

	localparam int Bubbles = 3;

	// --------------------
	// Run length in clock cycles
	localparam int ResetCycles   = 12;
	localparam int RTypeCycles   = 80;
	localparam int ImmCycles     = 16;
	localparam int BranchCycles  = 50;
	localparam int JumpCycles    = 12;
	localparam int SyscallCycles = 30;
	localparam int MarginCycles  = 100;
	localparam int TotalCycles   = ResetCycles + RTypeCycles + ImmCycles + BranchCycles
	                             + JumpCycles + SyscallCycles + MarginCycles;

	logic   CLK;
	logic   RESET;
	InstrU  instr;
	WordT   pca;
	WordT   exResult;
	FwdSrcT memFwd;
	FwdSrcT wbFwd;
	logic   freeze;
	IdExT   idEx;
	WordT   nextAddress;
	logic   takenBranch;
	logic   insertBubble;
	logic   sysOut;

	WordT        regVal [RegCount];  // Expected register contents
	logic [31:0] rngState;

	tbClock #(.Period(100), .ResetCycles(10)) clockGen (.CLK(CLK), .RESET(RESET));

	decodeStage #(.SyscallBubbles(Bubbles)) dut_i (
		.CLK (CLK), .RESET (RESET), .instr (instr), .pca (pca), .exResult (exResult),
		.memFwd (memFwd), .wbFwd (wbFwd), .freeze (freeze), .idEx (idEx),
		.nextAddress (nextAddress), .takenBranch (takenBranch),
		.insertBubble (insertBubble), .sysOut (sysOut)
	);

	// --------------------
	// Helpers
	function automatic WordT xorshift32();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	function automatic InstrU rIns(RegIdxT rs, RegIdxT rt, RegIdxT rd, logic [4:0] sh,
	                               logic [5:0] fn);
		InstrU i;
		i.rType = '{opcode: 6'b0, rs: rs, rt: rt, rd: rd, shamt: sh, funct: fn};
		return i;
	endfunction

	function automatic InstrU iIns(logic [5:0] op, RegIdxT rs, RegIdxT rt, logic [15:0] imm);
		InstrU i;
		i.iType = '{opcode: op, rs: rs, rt: rt, imm16: imm};
		return i;
	endfunction

	function automatic InstrU jIns(logic [5:0] op, logic [25:0] target);
		InstrU i;
		i.jType = '{opcode: op, target26: target};
		return i;
	endfunction

	function automatic WordT branchTarget(WordT p, logic [15:0] imm);
		int offset;
		offset = $signed(imm);  // Signed word offset
		return p + WordT'(offset * 4);
	endfunction

	// ALU-style bundle with the flags cleared
	function automatic IdExT expectedBundle(WordT a, WordT b, WordT st, RegIdxT dest,
	                                        RegIdxT sa, RegIdxT sb, AluOpT op, logic wb);
		IdExT e;
		e           = '0;
		e.opA       = a;
		e.opB       = b;
		e.storeData = st;
		e.dest      = dest;
		e.srcA      = sa;
		e.srcB      = sb;
		e.aluOp     = op;
		e.writeBack = wb;
		return e;
	endfunction

	// --------------------
	// Checks
	task automatic reportMismatch(string name, logic [31:0] got, logic [31:0] exp);
		$display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
		$display("Result: FAILED");
		$fatal(1, "value mismatch");
	endtask

	task automatic checkWord(string name, WordT got, WordT exp);
		if (got !== exp)
			reportMismatch(name, got, exp);
	endtask

	task automatic checkBit(string name, logic got, logic exp);
		if (got !== exp)
			reportMismatch(name, 32'(got), 32'(exp));
	endtask

	task automatic checkIdEx(IdExT got, IdExT exp);
		checkWord("idEx.opA", got.opA, exp.opA);
		checkWord("idEx.opB", got.opB, exp.opB);
		checkWord("idEx.storeData", got.storeData, exp.storeData);
		if (got.dest !== exp.dest) reportMismatch("idEx.dest", 32'(got.dest), 32'(exp.dest));
		if (got.srcA !== exp.srcA) reportMismatch("idEx.srcA", 32'(got.srcA), 32'(exp.srcA));
		if (got.srcB !== exp.srcB) reportMismatch("idEx.srcB", 32'(got.srcB), 32'(exp.srcB));
		if (got.shamt !== exp.shamt)
			reportMismatch("idEx.shamt", 32'(got.shamt), 32'(exp.shamt));
		if (got.aluOp !== exp.aluOp)
			reportMismatch("idEx.aluOp", 32'(got.aluOp), 32'(exp.aluOp));
		checkBit("idEx.memRead", got.memRead, exp.memRead);
		checkBit("idEx.memWrite", got.memWrite, exp.memWrite);
		checkBit("idEx.memToReg", got.memToReg, exp.memToReg);
		checkBit("idEx.aluSrc", got.aluSrc, exp.aluSrc);
		checkBit("idEx.writeBack", got.writeBack, exp.writeBack);
		checkBit("idEx.takenBranch", got.takenBranch, exp.takenBranch);
	endtask

	// --------------------
	// Drivers
	task automatic applyInputs(InstrU i, WordT p, WordT ex, FwdSrcT mem, FwdSrcT wb);
		@(posedge CLK);
		instr    <= i;
		pca      <= p;
		exResult <= ex;
		memFwd   <= mem;
		wbFwd    <= wb;
		@(negedge CLK);  // Combinational outputs settled
	endtask

	task automatic loadReg(RegIdxT idx, WordT val);
		applyInputs(rIns(0, 0, 0, 0, 0), 32'h0, 32'h0, '0, '{valid: 1'b1, dest: idx, data: val});
		applyInputs(rIns(0, 0, 0, 0, 0), 32'h0, 32'h0, '0, '0);
		regVal[idx] = val;
	endtask

	// Drive one instruction and check what the next edge captures
	task automatic issueAndCheck(InstrU i, WordT p, IdExT exp);
		applyInputs(i, p, 32'h0, '0, '0);
		@(negedge CLK);
		checkIdEx(idEx, exp);
	endtask

	task automatic checkBranch(InstrU i, WordT p, logic cond);
		applyInputs(i, p, 32'h0, '0, '0);
		checkBit("takenBranch", takenBranch, cond);
		checkWord("nextAddress", nextAddress, cond ? branchTarget(p, i.iType.imm16) : p);
	endtask

	// --------------------
	// Tests
	task automatic testReset();
		wait (RESET === 1'b1);
		@(negedge CLK);
		checkIdEx(idEx, '0);
		checkBit("insertBubble", insertBubble, 1'b0);
		checkBit("sysOut", sysOut, 1'b0);
	endtask

	task automatic testRType();
		IdExT e;
		for (int r = 1; r < RegCount; r++)
			loadReg(RegIdxT'(r), xorshift32());
		e = expectedBundle(regVal[1], regVal[2], regVal[2], 4, 1, 2, AluAdd, 1'b1);
		issueAndCheck(rIns(1, 2, 4, 0, 6'b100000), 32'h0, e);  // add
		e = expectedBundle(regVal[3], regVal[1], regVal[1], 5, 3, 1, AluSub, 1'b1);
		issueAndCheck(rIns(3, 1, 5, 0, 6'b100010), 32'h0, e);  // sub
		e = expectedBundle(regVal[1], regVal[3], regVal[3], 6, 1, 3, AluSllv, 1'b1);
		issueAndCheck(rIns(1, 3, 6, 0, 6'b000100), 32'h0, e);  // sllv
		e = expectedBundle(regVal[1], regVal[2], regVal[2], 0, 1, 2, AluAdd, 1'b0);
		issueAndCheck(rIns(1, 2, 0, 0, 6'b100000), 32'h0, e);  // rd of zero
		// Freeze holds the last capture
		e = expectedBundle(regVal[1], regVal[2], regVal[2], 4, 1, 2, AluAdd, 1'b1);
		issueAndCheck(rIns(1, 2, 4, 0, 6'b100000), 32'h0, e);
		@(posedge CLK);
		freeze <= 1'b1;
		instr  <= rIns(3, 1, 5, 0, 6'b100010);
		@(posedge CLK);
		@(negedge CLK);
		checkIdEx(idEx, e);
		@(posedge CLK);
		freeze <= 1'b0;
	endtask

	task automatic testImmediate();
		IdExT e;
		e = expectedBundle(regVal[1], 32'hFFFF_FFFB, regVal[7], 7, 1, 0, AluAdd, 1'b1);
		e.aluSrc = 1'b1;
		e.shamt  = 5'd31;  // imm16[10:6]
		issueAndCheck(iIns(6'b001000, 1, 7, 16'hFFFB), 32'h0, e);  // addi
		e = expectedBundle(regVal[2], 32'hFFFF_8000, regVal[8], 8, 2, 0, AluSlt, 1'b1);
		e.aluSrc = 1'b1;
		issueAndCheck(iIns(6'b001010, 2, 8, 16'h8000), 32'h0, e);  // slti
		e = expectedBundle(regVal[1], 32'h0000_8001, regVal[9], 9, 1, 0, AluOr, 1'b1);
		e.aluSrc = 1'b1;
		issueAndCheck(iIns(6'b001101, 1, 9, 16'h8001), 32'h0, e);  // ori
		e = expectedBundle(32'h0, 32'h0000_F234, regVal[10], 10, 0, 0, AluLui, 1'b1);
		e.aluSrc = 1'b1;
		e.shamt  = 5'd8;
		issueAndCheck(iIns(6'b001111, 0, 10, 16'hF234), 32'h0, e);  // lui
		e = expectedBundle(regVal[1], 32'h8, regVal[11], 11, 1, 0, AluAddu, 1'b1);
		e.aluSrc   = 1'b1;
		e.memRead  = 1'b1;
		e.memToReg = 1'b1;
		issueAndCheck(iIns(6'b100011, 1, 11, 16'h0008), 32'h0, e);  // lw
		e = expectedBundle(regVal[1], 32'hFFFF_FFFC, regVal[12], 12, 1, 0, AluAddu, 1'b0);
		e.aluSrc   = 1'b1;
		e.memWrite = 1'b1;
		e.shamt    = 5'd31;
		issueAndCheck(iIns(6'b101011, 1, 12, 16'hFFFC), 32'h0, e);  // sw
	endtask

	task automatic testBranches();
		WordT   p;
		FwdSrcT neg17;
		p     = 32'h0040_0100;
		neg17 = '{valid: 1'b1, dest: 17, data: 32'hFFFF_FF00};
		loadReg(13, 32'd100);
		loadReg(14, 32'hFFFF_FFF9);
		loadReg(15, 32'd100);
		loadReg(16, 32'h0);
		loadReg(17, 32'd55);
		checkBranch(iIns(6'b000100, 13, 15, 16'h0010), p, 1'b1);  // beq
		checkBranch(iIns(6'b000100, 13, 14, 16'h0010), p, 1'b0);
		checkBranch(iIns(6'b000101, 13, 14, 16'hFFF0), p, 1'b1);  // bne
		checkBranch(iIns(6'b000110, 16, 0, 16'h0020), p, 1'b1);   // blez
		checkBranch(iIns(6'b000110, 13, 0, 16'h0020), p, 1'b0);
		checkBranch(iIns(6'b000111, 13, 0, 16'hFFFE), p, 1'b1);   // bgtz
		checkBranch(iIns(6'b000111, 14, 0, 16'hFFFE), p, 1'b0);
		checkBranch(iIns(6'b000001, 14, 0, 16'h0004), p, 1'b1);   // bltz
		checkBranch(iIns(6'b000001, 16, 1, 16'h0004), p, 1'b1);   // bgez
		checkBranch(iIns(6'b000001, 14, 1, 16'h0004), p, 1'b0);
		// Forwarded rs on bltz r17
		checkBranch(iIns(6'b000001, 17, 0, 16'h0008), p, 1'b0);
		applyInputs(iIns(6'b000001, 17, 0, 16'h0008), p, 32'h0, neg17, '0);
		checkBit("takenBranch", takenBranch, 1'b1);
		applyInputs(iIns(6'b000001, 17, 0, 16'h0008), p, 32'h0, '0, neg17);
		checkBit("takenBranch", takenBranch, 1'b1);
		regVal[17] = neg17.data;  // WB forward also wrote r17
		loadReg(17, 32'd55);
		// EX beats MEM and WB
		applyInputs(rIns(0, 0, 17, 0, 6'b100001), p, 32'h0, '0, '0);
		applyInputs(iIns(6'b000001, 17, 0, 16'h0008), p, 32'd9, neg17, neg17);
		checkBit("takenBranch", takenBranch, 1'b0);
		checkWord("nextAddress", nextAddress, p);
		regVal[17] = neg17.data;
		applyInputs(rIns(0, 0, 0, 0, 0), p, 32'h0, '0, '0);
	endtask

	task automatic testJumps();
		WordT  p;
		InstrU i;
		IdExT  e;
		p = 32'hA000_0040;
		applyInputs(jIns(6'b000010, 26'h012_3456), p, 32'h0, '0, '0);  // j
		checkBit("takenBranch", takenBranch, 1'b1);
		checkWord("nextAddress", nextAddress, {4'hA, 26'h012_3456, 2'b00});
		applyInputs(rIns(19, 0, 0, 0, 6'b001000), p, 32'h0,
		            '{valid: 1'b1, dest: 19, data: 32'h0040_0800}, '0);  // jr
		checkWord("nextAddress", nextAddress, 32'h0040_0800);
		i = jIns(6'b000011, 26'h2A5_5A5A);  // jal
		e = expectedBundle(p, LinkOffset, regVal[i.rType.rt], 31, 0, 0, AluAddu, 1'b1);
		e.shamt       = i.rType.shamt;
		e.takenBranch = 1'b1;
		issueAndCheck(i, p, e);
		e = expectedBundle(p, LinkOffset, 32'h0, 21, 0, 0, AluAddu, 1'b1);  // jalr
		e.takenBranch = 1'b1;
		applyInputs(rIns(20, 0, 21, 0, 6'b001001), p, 32'h0, '0, '0);
		checkWord("nextAddress", nextAddress, regVal[20]);
		@(negedge CLK);
		checkIdEx(idEx, e);
	endtask

	// Hold a syscall with some frozen edges and count the bubble cycles
	task automatic runSyscall(int freezeAt, int freezeLen);
		int   count;
		IdExT e;
		count = 0;
		applyInputs(rIns(0, 0, 0, 0, 6'b001100), 32'h0, 32'h0, '0, '0);
		for (int c = 0; c < 50; c++) begin
			if (c > 0)
				checkIdEx(idEx, '0);
			if (sysOut === 1'b1)
				break;
			checkBit("insertBubble", insertBubble, 1'b1);
			count++;
			@(posedge CLK);
			freeze <= (c + 1 >= freezeAt) && (c + 1 < freezeAt + freezeLen);
			@(negedge CLK);
		end
		if (sysOut !== 1'b1) begin
			$display("Syscall never reached its issue cycle");
			$display("Result: FAILED");
			$fatal(1, "syscall stuck");
		end
		checkBit("insertBubble", insertBubble, 1'b0);
		checkWord("bubble cycles", 32'(count), 32'(Bubbles + freezeLen));
		e = expectedBundle(regVal[SysArgReg], 32'h0, 32'h0, 0, 0, 0, AluAddu, 1'b0);
		applyInputs(rIns(0, 0, 0, 0, 0), 32'h0, 32'h0, '0, '0);  // Issue edge
		checkIdEx(idEx, e);
	endtask

	task automatic testSyscall();
		loadReg(SysArgReg, xorshift32());
		runSyscall(0, 0);
		runSyscall(1, 2);
	endtask

	// --------------------
	// Watchdog
	initial begin
		#(TotalCycles * 100);
		$display("Watchdog expired before the tests finished");
		$display("Result: FAILED");
		$fatal(1, "timeout");
	end

	initial begin
		instr    = '0;
		pca      = '0;
		exResult = '0;
		memFwd   = '0;
		wbFwd    = '0;
		freeze   = 1'b0;
		rngState = 32'd73;
		regVal[0] = '0;
		testReset();
		testRType();
		testImmediate();
		testBranches();
		testJumps();
		testSyscall();
		$display("Result: PASSED");
		$finish;
	end

endmodule

// ==== list.f ====
logic/decodePkg.sv
logic/controlDecoder.sv
logic/registerFile.sv
logic/operandForward.sv
logic/branchResolve.sv
logic/idExRegister.sv
logic/decodeStage.sv
verif/tbClock.sv
verif/decodeStageTb.sv

// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - logic/decodePkg.sv
  - logic/controlDecoder.sv
  - logic/registerFile.sv
  - logic/operandForward.sv
  - logic/branchResolve.sv
  - logic/idExRegister.sv
  - logic/decodeStage.sv
  - target: test
    files:
      - verif/tbClock.sv
      - verif/decodeStageTb.sv
